// File: source/wedge_word_pkg.sv
package wedge_word_pkg;

	//////////////////////////////////////////////////////////////////////
	// link word geometry

	localparam int WORD_WIDTH = 23;
	localparam int ROADID_WIDTH = WORD_WIDTH - 2; // everything below ee and ep
	localparam int CHISQ_WIDTH = 13;
	localparam int TRACK_WIDTH = 8;

	// bit of the end-event word that carries the output parity
	localparam int PARITY_BIT = 8;

	// one word on the link
	// road-id word: payload is the road id
	// candidate word: payload is chisq (upper) over track number (lower)
	// end-event word: payload is error bits and event tag
	typedef struct packed {
		logic ee; // end of event
		logic ep; // end of road
		logic [ROADID_WIDTH-1:0] payload;
	} wedge_word_t;

endpackage

// File: source/fitter_pkg.sv
package fitter_pkg;

	import wedge_word_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// buffer sizes

	localparam int IN_DEPTH = 16;
	localparam int OUT_DEPTH = 16;
	localparam int TRACK_DEPTH = 8; // roads waiting for the formatter
	localparam int HOLD_LEVEL = IN_DEPTH - 4; // leaves room for words already in flight

	// best candidate of one road
	typedef struct packed {
		logic [ROADID_WIDTH-1:0] road_id;
		logic [CHISQ_WIDTH-1:0] chisq;
		logic [TRACK_WIDTH-1:0] track;
	} best_track_t;

	// status word, error bits sticky, empty bits live
	typedef struct packed {
		logic in_overflow;
		logic out_overflow;
		logic invalid_road;
		logic in_empty;
		logic out_empty;
	} wedge_status_t;

endpackage

// File: source/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
	parameter type payload_t = logic [22:0],
	parameter int DEPTH = 16,
	parameter int AFULL_LEVEL = 12
) (
	input logic clock,
	input logic reset,
	// write side
	input logic push,
	input payload_t din,
	output logic full,
	output logic almost_full,
	output logic overflow,
	// read side, first word shown at the head
	output logic out_valid,
	input logic out_ready,
	output payload_t dout,
	output logic empty
);

	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = out_valid && out_ready;

	assign full = (count == CNT_WIDTH'(DEPTH));
	assign almost_full = (count >= CNT_WIDTH'(AFULL_LEVEL));
	assign empty = (count == '0);
	assign overflow = push && full; // word is lost
	assign out_valid = !empty;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (reset) count <= CNT_WIDTH'(DEPTH))
		else $error("word_fifo: fill count above depth");

endmodule

// File: source/fitter_control.sv
`timescale 1ns/1ps

module fitter_control import wedge_word_pkg::*, fitter_pkg::*; (
	input logic clock,
	input logic reset,
	// input FIFO head
	input logic in_valid,
	output logic in_ready,
	input wedge_word_t in_word,
	// commands to the compare
	output logic start_road,
	output logic [ROADID_WIDTH-1:0] road_id,
	output logic cand_valid,
	output logic [CHISQ_WIDTH-1:0] cand_chisq,
	output logic [TRACK_WIDTH-1:0] cand_track,
	output logic cand_last,
	input logic decision_valid,
	input logic pass,
	input best_track_t best,
	// track FIFO
	output logic track_push,
	input logic track_full,
	input logic track_empty,
	// end-event handoff
	output logic ee_valid,
	output wedge_word_t ee_word,
	input logic ee_ready,
	input logic formatter_busy,
	output logic invalid_road
);

	typedef enum logic [1:0] {idle, in_road, wait_drain} ctl_state_t;

	ctl_state_t state;
	ctl_state_t state_next;
	logic drained;

	// fields straight off the head word, qualified by the strobes below
	assign road_id = in_word.payload;
	assign cand_chisq = in_word.payload[TRACK_WIDTH +: CHISQ_WIDTH];
	assign cand_track = in_word.payload[TRACK_WIDTH-1:0];
	assign cand_last = in_word.ep;
	assign ee_word = in_word;

	assign track_push = decision_valid && pass;

	// no track left anywhere ahead of the end event
	assign drained = track_empty && !formatter_busy && !decision_valid;

	always_comb
	begin
		state_next = state;
		in_ready = 1'b0;
		start_road = 1'b0;
		cand_valid = 1'b0;
		ee_valid = 1'b0;
		invalid_road = 1'b0;
		case (state)
			idle:
			begin
				if (in_valid && in_word.ee)
					state_next = wait_drain; // head stays until the formatter takes it
				else if (in_valid && !track_full)
				begin
					in_ready = 1'b1;
					if (in_word.ep)
						invalid_road = 1'b1; // orphan ep word, dropped
					else
					begin
						start_road = 1'b1;
						state_next = in_road;
					end
				end
			end
			in_road:
			begin
				if (in_valid && in_word.ee)
				begin
					invalid_road = 1'b1; // road cut short by the event end
					state_next = wait_drain;
				end
				else if (in_valid && !track_full)
				begin
					in_ready = 1'b1;
					cand_valid = 1'b1;
					if (in_word.ep)
						state_next = idle;
				end
			end
			wait_drain:
			begin
				ee_valid = in_valid && drained;
				if (ee_valid && ee_ready)
				begin
					in_ready = 1'b1;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	assert property (@(posedge clock) disable iff (reset) track_push |-> !track_full)
		else $error("fitter_control: track push into a full FIFO");

endmodule

// File: source/chisq_compare.sv
`timescale 1ns/1ps

module chisq_compare import wedge_word_pkg::*, fitter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start_road,
	input logic [ROADID_WIDTH-1:0] road_id,
	input logic cand_valid,
	input logic [CHISQ_WIDTH-1:0] cand_chisq,
	input logic [TRACK_WIDTH-1:0] cand_track,
	input logic cand_last,
	input logic nocut,
	input logic [CHISQ_WIDTH-1:0] chi2cut_value,
	output logic decision_valid,
	output logic pass,
	output best_track_t best
);

	logic [ROADID_WIDTH-1:0] cur_road;
	logic [CHISQ_WIDTH-1:0] best_chisq;
	logic [TRACK_WIDTH-1:0] best_track;
	logic [CHISQ_WIDTH-1:0] next_chisq;
	logic [TRACK_WIDTH-1:0] next_track;
	logic have_cand;
	logic take;

	// strictly smaller wins, a tie keeps the earlier one
	assign take = !have_cand || (cand_chisq < best_chisq);
	assign next_chisq = take ? cand_chisq : best_chisq;
	assign next_track = take ? cand_track : best_track;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			have_cand <= 1'b0;
			decision_valid <= 1'b0;
		end
		else
		begin
			decision_valid <= cand_valid && cand_last;
			if (start_road)
				have_cand <= 1'b0;
			else if (cand_valid)
				have_cand <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start_road)
			cur_road <= road_id;
		if (cand_valid)
		begin
			best_chisq <= next_chisq;
			best_track <= next_track;
		end
		if (cand_valid && cand_last)
		begin
			best.road_id <= cur_road;
			best.chisq <= next_chisq;
			best.track <= next_track;
			pass <= nocut || (next_chisq <= chi2cut_value); // cut is inclusive
		end
	end

endmodule

// File: source/track_formatter.sv
`timescale 1ns/1ps

module track_formatter import wedge_word_pkg::*, fitter_pkg::*; (
	input logic clock,
	input logic reset,
	// track FIFO head
	input logic trk_valid,
	output logic trk_ready,
	input best_track_t trk,
	// end event from the control
	input logic ee_valid,
	output logic ee_ready,
	input wedge_word_t ee_word,
	output logic busy,
	// output FIFO write side
	output logic out_push,
	output wedge_word_t out_word,
	input logic out_full
);

	typedef enum logic [1:0] {idle, track_word, end_event} fmt_state_t;

	fmt_state_t state;
	fmt_state_t state_next;
	wedge_word_t ee_hold;
	logic parity; // over track words since the last end event

	assign busy = (state != idle);

	always_comb
	begin
		state_next = state;
		trk_ready = 1'b0;
		ee_ready = 1'b0;
		out_push = 1'b0;
		out_word = '0;
		case (state)
			idle:
			begin
				out_word.payload = trk.road_id; // road-id word, ee and ep clear
				if (trk_valid)
				begin
					out_push = !out_full;
					if (!out_full)
						state_next = track_word;
				end
				else if (ee_valid)
				begin
					ee_ready = 1'b1;
					state_next = end_event;
				end
			end
			track_word:
			begin
				out_word.ep = 1'b1;
				out_word.payload = {trk.chisq, trk.track};
				if (!out_full)
				begin
					out_push = 1'b1;
					trk_ready = 1'b1; // head popped only after both words
					state_next = idle;
				end
			end
			end_event:
			begin
				out_word = ee_hold;
				out_word.payload[PARITY_BIT] = parity;
				if (!out_full)
				begin
					out_push = 1'b1;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			parity <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (out_push && state == end_event)
				parity <= 1'b0;
			else if (out_push)
				parity <= parity ^ (^out_word);
		end
	end

	always_ff @(posedge clock)
	begin
		if (ee_valid && ee_ready)
			ee_hold <= ee_word;
	end

	assert property (@(posedge clock) disable iff (reset) out_push |-> !out_full)
		else $error("track_formatter: push into a full output FIFO");

endmodule

// File: source/status_flags.sv
`timescale 1ns/1ps

module status_flags import fitter_pkg::*; (
	input logic clock,
	input logic clear_status,
	input logic in_overflow,
	input logic out_overflow,
	input logic invalid_road,
	input logic in_empty,
	input logic out_empty,
	output wedge_status_t status
);

	logic in_overflow_seen;
	logic out_overflow_seen;
	logic invalid_seen;

	always_ff @(posedge clock)
	begin
		if (clear_status)
		begin
			in_overflow_seen <= 1'b0;
			out_overflow_seen <= 1'b0;
			invalid_seen <= 1'b0;
		end
		else
		begin
			in_overflow_seen <= in_overflow_seen | in_overflow;
			out_overflow_seen <= out_overflow_seen | out_overflow;
			invalid_seen <= invalid_seen | invalid_road;
		end
	end

	always_comb
	begin
		status.in_overflow = in_overflow_seen;
		status.out_overflow = out_overflow_seen;
		status.invalid_road = invalid_seen;
		status.in_empty = in_empty; // live
		status.out_empty = out_empty;
	end

endmodule

// File: source/wedge_fitter.sv
`timescale 1ns/1ps

module wedge_fitter import wedge_word_pkg::*, fitter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic clear_status,
	input wedge_word_t data_in,
	input logic ds,
	output logic hold,
	input logic out_re,
	output wedge_word_t data_out,
	output logic out_valid,
	output logic out_empty,
	input logic nocut,
	input logic [CHISQ_WIDTH-1:0] chi2cut_value,
	output wedge_status_t wedge_status
);

	logic in_valid;
	logic in_ready;
	wedge_word_t in_word;
	logic in_overflow;
	logic in_empty;
	logic start_road;
	logic [ROADID_WIDTH-1:0] road_id;
	logic cand_valid;
	logic [CHISQ_WIDTH-1:0] cand_chisq;
	logic [TRACK_WIDTH-1:0] cand_track;
	logic cand_last;
	logic decision_valid;
	logic pass;
	best_track_t best;
	logic track_push;
	logic track_full;
	logic track_empty;
	logic trk_valid;
	logic trk_ready;
	best_track_t trk;
	logic ee_valid;
	logic ee_ready;
	wedge_word_t ee_word;
	logic formatter_busy;
	logic invalid_road;
	logic out_push;
	wedge_word_t out_word;
	logic out_full;
	logic out_overflow;
	logic out_fifo_valid;
	wedge_word_t out_fifo_word;

	//////////////////////////////////////////////////////////////////////
	// input side, hold comes from the fill level

	word_fifo #(
		.payload_t(wedge_word_t),
		.DEPTH(IN_DEPTH),
		.AFULL_LEVEL(HOLD_LEVEL)
	) u_fifo_in (
		.clock(clock),
		.reset(reset),
		.push(ds),
		.din(data_in),
		.full(),
		.almost_full(hold),
		.overflow(in_overflow),
		.out_valid(in_valid),
		.out_ready(in_ready),
		.dout(in_word),
		.empty(in_empty)
	);

	fitter_control u_fitter_control (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_word(in_word),
		.start_road(start_road),
		.road_id(road_id),
		.cand_valid(cand_valid),
		.cand_chisq(cand_chisq),
		.cand_track(cand_track),
		.cand_last(cand_last),
		.decision_valid(decision_valid),
		.pass(pass),
		.best(best),
		.track_push(track_push),
		.track_full(track_full),
		.track_empty(track_empty),
		.ee_valid(ee_valid),
		.ee_word(ee_word),
		.ee_ready(ee_ready),
		.formatter_busy(formatter_busy),
		.invalid_road(invalid_road)
	);

	chisq_compare u_chisq_compare (
		.clock(clock),
		.reset(reset),
		.start_road(start_road),
		.road_id(road_id),
		.cand_valid(cand_valid),
		.cand_chisq(cand_chisq),
		.cand_track(cand_track),
		.cand_last(cand_last),
		.nocut(nocut),
		.chi2cut_value(chi2cut_value),
		.decision_valid(decision_valid),
		.pass(pass),
		.best(best)
	);

	//////////////////////////////////////////////////////////////////////
	// passing tracks wait here for the formatter

	word_fifo #(
		.payload_t(best_track_t),
		.DEPTH(TRACK_DEPTH),
		.AFULL_LEVEL(TRACK_DEPTH)
	) u_fifo_track (
		.clock(clock),
		.reset(reset),
		.push(track_push),
		.din(best),
		.full(track_full),
		.almost_full(),
		.overflow(),
		.out_valid(trk_valid),
		.out_ready(trk_ready),
		.dout(trk),
		.empty(track_empty)
	);

	track_formatter u_track_formatter (
		.clock(clock),
		.reset(reset),
		.trk_valid(trk_valid),
		.trk_ready(trk_ready),
		.trk(trk),
		.ee_valid(ee_valid),
		.ee_ready(ee_ready),
		.ee_word(ee_word),
		.busy(formatter_busy),
		.out_push(out_push),
		.out_word(out_word),
		.out_full(out_full)
	);

	word_fifo #(
		.payload_t(wedge_word_t),
		.DEPTH(OUT_DEPTH),
		.AFULL_LEVEL(OUT_DEPTH)
	) u_fifo_out (
		.clock(clock),
		.reset(reset),
		.push(out_push),
		.din(out_word),
		.full(out_full),
		.almost_full(),
		.overflow(out_overflow),
		.out_valid(out_fifo_valid),
		.out_ready(out_re),
		.dout(out_fifo_word),
		.empty(out_empty)
	);

	// read port, popped word shows one cycle after out_re
	always_ff @(posedge clock)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= out_fifo_valid && out_re;
	end

	always_ff @(posedge clock)
	begin
		if (out_fifo_valid && out_re)
			data_out <= out_fifo_word;
	end

	status_flags u_status_flags (
		.clock(clock),
		.clear_status(clear_status || reset), // flags start low out of reset
		.in_overflow(in_overflow),
		.out_overflow(out_overflow),
		.invalid_road(invalid_road),
		.in_empty(in_empty),
		.out_empty(out_empty),
		.status(wedge_status)
	);

endmodule

// File: bench/wedge_fitter_tb.sv
`timescale 1ns/1ps

module wedge_fitter_tb import wedge_word_pkg::*, fitter_pkg::*;;

	localparam int STIM_MAX = 256;
	localparam int WAIT_LIMIT = 400; // cycles without progress
	localparam int QUIET_CYCLES = 12; // longer than the whole pipeline
	localparam logic [31:0] RAND_SEED = 32'hd5b70cfb;

	logic clock;
	logic reset;
	logic clear_status;
	wedge_word_t data_in;
	logic ds;
	logic hold;
	logic out_re;
	wedge_word_t data_out;
	logic out_valid;
	logic out_empty;
	logic nocut;
	logic [CHISQ_WIDTH-1:0] chi2cut_value;
	wedge_status_t wedge_status;

	logic [31:0] stim [STIM_MAX];
	wedge_word_t in_q [$];
	wedge_word_t exp_q [$];
	logic stall_mode;
	logic hold_seen;
	logic reading_done;
	logic timed_out;
	logic bad_file;
	logic test_open;
	int test_num;
	int test_err_start;
	int checks;
	int errors;
	int tests_passed;
	int tests_failed;

	wedge_fitter DUT (
		.clock(clock),
		.reset(reset),
		.clear_status(clear_status),
		.data_in(data_in),
		.ds(ds),
		.hold(hold),
		.out_re(out_re),
		.data_out(data_out),
		.out_valid(out_valid),
		.out_empty(out_empty),
		.nocut(nocut),
		.chi2cut_value(chi2cut_value),
		.wedge_status(wedge_status)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus side

	task automatic drive_inputs();
		int idx;
		int waited;
		idx = 0;
		waited = 0;
		while (idx < in_q.size() && !timed_out)
		begin
			@(negedge clock);
			if (!hold)
			begin
				ds = 1'b1;
				data_in = in_q[idx];
				idx++;
				waited = 0;
			end
			else
			begin
				ds = 1'b0; // source respects hold
				waited++;
				if (waited > WAIT_LIMIT)
				begin
					$display("timeout in test %0d: hold stayed high too long", test_num);
					timed_out = 1'b1;
				end
			end
		end
		@(negedge clock);
		ds = 1'b0;
	endtask

	// out_re held low until the input side backs up, then random stalls
	task automatic pace_reads();
		while (!reading_done && !timed_out)
		begin
			@(negedge clock);
			if (hold)
				hold_seen = 1'b1;
			if (!stall_mode)
				out_re = 1'b1;
			else if (!hold_seen)
				out_re = 1'b0;
			else
				out_re = (($urandom % 4) != 0); // roughly one stall in four
		end
	endtask

	task automatic collect_outputs();
		int got;
		int idle;
		got = 0;
		idle = 0;
		while (got < exp_q.size() && !timed_out)
		begin
			@(negedge clock);
			if (out_valid)
			begin
				checks++;
				assert (data_out == exp_q[got])
				else
				begin
					$display("error at time %0t: test %0d word %0d expected %06h got %06h",
						$time, test_num, got, exp_q[got], data_out);
					errors++;
				end
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > WAIT_LIMIT)
				begin
					$display("timeout in test %0d: only %0d of %0d words came out",
						test_num, got, exp_q.size());
					timed_out = 1'b1;
				end
			end
		end
		reading_done = 1'b1;
	endtask

	// nothing buffered anywhere, hold down
	task automatic check_drained();
		checks++;
		assert (out_empty && wedge_status.out_empty && wedge_status.in_empty
			&& !hold && !out_valid)
		else
		begin
			$display("error at time %0t: test %0d FIFOs not drained, out_empty %0b hold %0b",
				$time, test_num, out_empty, hold);
			errors++;
		end
	endtask

	task automatic run_test();
		int waited;
		int quiet;
		hold_seen = 1'b0;
		reading_done = 1'b0;
		fork
			drive_inputs();
			collect_outputs();
			pace_reads();
		join
		out_re = 1'b1; // anything left over shows up below
		if (stall_mode && !timed_out)
		begin
			assert (hold_seen)
			else
			begin
				$display("error at time %0t: test %0d hold never rose during the burst",
					$time, test_num);
				errors++;
			end
		end
		waited = 0;
		while (!wedge_status.in_empty && !timed_out)
		begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT)
			begin
				$display("timeout in test %0d: input FIFO never drained", test_num);
				timed_out = 1'b1;
			end
		end
		quiet = 0;
		while (quiet < QUIET_CYCLES && !timed_out)
		begin
			@(negedge clock);
			quiet++;
			assert (!out_valid)
			else
			begin
				$display("error at time %0t: test %0d extra output word %06h",
					$time, test_num, data_out);
				errors++;
			end
		end
		if (!timed_out)
			check_drained();
		in_q.delete();
		exp_q.delete();
	endtask

	// sticky error bits, in_overflow over out_overflow over invalid_road
	task automatic check_flags(input logic [2:0] expected);
		checks++;
		assert ({wedge_status.in_overflow, wedge_status.out_overflow,
			wedge_status.invalid_road} == expected)
		else
		begin
			$display("error at time %0t: test %0d status flags expected %03b got %03b",
				$time, test_num, expected, {wedge_status.in_overflow,
				wedge_status.out_overflow, wedge_status.invalid_road});
			errors++;
		end
	endtask

	task automatic pulse_clear();
		@(negedge clock);
		clear_status = 1'b1;
		@(negedge clock);
		clear_status = 1'b0;
	endtask

	task automatic report_test();
		if (errors == test_err_start && !timed_out)
		begin
			tests_passed++;
			$display("test %0d passed", test_num);
		end
		else
		begin
			tests_failed++;
			$display("test %0d failed with %0d errors", test_num, errors - test_err_start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence, one stimulus line at a time

	initial
	begin
		int line;
		logic [31:0] entry;
		logic done;
		void'($urandom(RAND_SEED));
		reset = 1'b1;
		clear_status = 1'b0;
		data_in = '0;
		ds = 1'b0;
		out_re = 1'b1;
		nocut = 1'b0;
		chi2cut_value = '0;
		stall_mode = 1'b0;
		hold_seen = 1'b0;
		reading_done = 1'b0;
		timed_out = 1'b0;
		bad_file = 1'b0;
		test_open = 1'b0;
		test_num = 0;
		test_err_start = 0;
		checks = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		$readmemh("bench/wedge_stim.txt", stim);
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_drained(); // state right out of reset
		check_flags(3'b000);

		line = 0;
		done = 1'b0;
		while (!done && !timed_out)
		begin
			if (line >= STIM_MAX)
			begin
				$display("stimulus file ends without an end marker");
				bad_file = 1'b1;
				done = 1'b1;
			end
			else
			begin
				entry = stim[line[7:0]];
				line++;
				case (entry[31:28])
					4'h1:
					begin
						if (test_open)
							report_test();
						test_open = 1'b1;
						test_num = int'(entry[22:0]);
						test_err_start = errors;
					end
					4'h2: nocut = entry[0];
					4'h3: chi2cut_value = entry[CHISQ_WIDTH-1:0];
					4'h4: stall_mode = entry[0];
					4'h5: in_q.push_back(entry[WORD_WIDTH-1:0]);
					4'h6: exp_q.push_back(entry[WORD_WIDTH-1:0]);
					4'h7: check_flags(entry[2:0]);
					4'h8: pulse_clear();
					4'h9: run_test();
					4'hf: done = 1'b1;
					default:
					begin
						$display("stimulus line %0d has an unknown kind", line);
						bad_file = 1'b1;
						done = 1'b1;
					end
				endcase
			end
		end
		if (test_open)
			report_test();

		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out && !bad_file)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: bench/wedge_stim.txt
// one entry per line: kind in the top hex digit, value in the low 23 bits
// 1 test, 2 nocut, 3 cut, 4 stall, 5 input word, 6 expected word,
// 7 expected error flags {in_ovf,out_ovf,invalid}, 8 clear status, 9 run, F end
// test 1: single candidate under the cut
10000001
20000000
30000100
40000000
5000A1B2
50204017
6000A1B2
60204017
90000000
// test 2: lowest chisq wins, ties keep the earlier candidate
10000002
50012345
5000F001
50003002
50005003
50203004
50000777
500020AA
502020BB
60012345
60203002
60000777
602020AA
90000000
// test 3: chisq above the cut is dropped, equal to the cut passes
10000003
50005555
50210133
50006666
50210044
60006666
60210044
90000000
// test 4: the dropped road passes with nocut
10000004
20000001
50005555
50210133
60005555
60210133
90000000
// test 5: end events, parity over tests 1 to 4 is even
10000005
20000000
50400F5A
50000011
50200101
50401234
60400E5A
60000011
60200101
60401334
90000000
// test 6: output stalled until hold rises, then random reads
10000006
40000001
50000101
50200101
50000102
50200202
50000103
50200303
50000104
50200404
50000105
50200505
50000106
50200606
50000107
50200707
50000108
50200808
50000109
50200909
50400000
5000000A
5000C001
5000B002
5000A003
50009004
50008005
50007006
50006007
50005008
50004009
5000300A
5020350B
5040C0FF
60000101
60200101
60000102
60200202
60000103
60200303
60000104
60200404
60000105
60200505
60000106
60200606
60000107
60200707
60000108
60200808
60000109
60200909
60400100
6000000A
6020300A
6040C1FF
90000000
70000000
// test 7: road id with ep set is dropped and flagged
10000007
40000000
50212121
90000000
70000001
80000000
70000000
F0000000

// File: wedge_fitter.f
source/wedge_word_pkg.sv
source/fitter_pkg.sv
source/word_fifo.sv
source/fitter_control.sv
source/chisq_compare.sv
source/track_formatter.sv
source/status_flags.sv
source/wedge_fitter.sv
bench/wedge_fitter_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" && rm -f sim.log \
	&& verilator --binary --timing --assert --top-module wedge_fitter_tb -f wedge_fitter.f -o wedge_sim \
	&& (./obj_dir/wedge_sim > sim.log 2>&1 || true) \
	&& cat sim.log && grep -qx "RESULT: PASS" sim.log \
	|| { echo "wedge_fitter simulation failed"; exit 1; }
